// File: logic/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_GPR    = 31;

    localparam logic [XLEN-1:0] INSTR_STEP = 32'd4;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // integer operations
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // only word access is supported
    localparam logic [2:0] F3_WORD = 3'b010;

    // sub and sra select the alternate encoding
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0]
    {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0]
    {
        class_alu,
        class_lui,
        class_auipc,
        class_jal,
        class_jalr,
        class_branch,
        class_load,
        class_store
    } instr_class_t;

    typedef enum logic [2:0]
    {
        state_fetch,
        state_fetch_wait,
        state_decode,
        state_execute,
        state_load_wait,
        state_load_done
    } core_state_t;

endpackage

// File: logic/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder
    import rv_core_pkg::*;
(
    input  logic [XLEN-1:0]       i_instr,

    output logic [6:0]            o_opcode,
    output logic [REG_ADDR_W-1:0] o_rd,
    output logic [REG_ADDR_W-1:0] o_rs1,
    output logic [REG_ADDR_W-1:0] o_rs2,
    output logic [2:0]            o_funct3,
    output logic [XLEN-1:0]       o_imm,
    output alu_op_t               o_alu_op,
    output instr_class_t          o_class,
    output logic                  o_valid
);

logic [6:0] w_funct7;

logic [XLEN-1:0] w_imm_i;
logic [XLEN-1:0] w_imm_s;
logic [XLEN-1:0] w_imm_b;
logic [XLEN-1:0] w_imm_u;
logic [XLEN-1:0] w_imm_j;

alu_op_t w_base_op;

assign o_opcode = i_instr[6:0];
assign o_rd     = i_instr[11:7];
assign o_funct3 = i_instr[14:12];
assign o_rs1    = i_instr[19:15];
assign o_rs2    = i_instr[24:20];
assign w_funct7 = i_instr[31:25];

assign w_imm_i = { { 20 { i_instr[31] } }, i_instr[31:20] };
assign w_imm_s = { { 20 { i_instr[31] } }, i_instr[31:25], i_instr[11:7] };
assign w_imm_b = { { 19 { i_instr[31] } }, i_instr[31], i_instr[7], i_instr[30:25],
                   i_instr[11:8], 1'b0 };
assign w_imm_u = { i_instr[31:12], 12'b0 };
assign w_imm_j = { { 11 { i_instr[31] } }, i_instr[31], i_instr[19:12], i_instr[20],
                   i_instr[30:21], 1'b0 };

// operation for the plain funct7 encoding
always_comb
    case (o_funct3)
        F3_ADD:  w_base_op = alu_add;
        F3_SLL:  w_base_op = alu_sll;
        F3_SLT:  w_base_op = alu_slt;
        F3_SLTU: w_base_op = alu_sltu;
        F3_XOR:  w_base_op = alu_xor;
        F3_SR:   w_base_op = alu_srl;
        F3_OR:   w_base_op = alu_or;
        default: w_base_op = alu_and;
    endcase

always_comb
    begin
        o_imm    = w_imm_i;
        o_alu_op = alu_add;
        o_class  = class_alu;
        o_valid  = 1'b0;

        case (o_opcode)
            OP_LUI:
                begin
                    o_imm   = w_imm_u;
                    o_class = class_lui;
                    o_valid = 1'b1;
                end
            OP_AUIPC:
                begin
                    o_imm   = w_imm_u;
                    o_class = class_auipc;
                    o_valid = 1'b1;
                end
            OP_JAL:
                begin
                    o_imm   = w_imm_j;
                    o_class = class_jal;
                    o_valid = 1'b1;
                end
            OP_JALR:
                begin
                    o_class = class_jalr;
                    o_valid = (o_funct3 == 3'b000);
                end
            OP_BRANCH:
                begin
                    o_imm   = w_imm_b;
                    o_class = class_branch;
                    o_valid = (o_funct3 != 3'b010) && (o_funct3 != 3'b011);
                end
            OP_LOAD:
                begin
                    o_class = class_load;
                    o_valid = (o_funct3 == F3_WORD);
                end
            OP_STORE:
                begin
                    o_imm   = w_imm_s;
                    o_class = class_store;
                    o_valid = (o_funct3 == F3_WORD);
                end
            OP_IMM:
                begin
                    o_alu_op = w_base_op;
                    // shift immediates carry funct7 in the upper bits
                    if ((o_funct3 != F3_SLL && o_funct3 != F3_SR) || w_funct7 == F7_BASE)
                        o_valid = 1'b1;
                    else if (o_funct3 == F3_SR && w_funct7 == F7_ALT)
                        begin
                            o_alu_op = alu_sra;
                            o_valid  = 1'b1;
                        end
                end
            OP_REG:
                begin
                    o_alu_op = w_base_op;
                    if (w_funct7 == F7_BASE)
                        o_valid = 1'b1;
                    else if (w_funct7 == F7_ALT && o_funct3 == F3_ADD)
                        begin
                            o_alu_op = alu_sub;
                            o_valid  = 1'b1;
                        end
                    else if (w_funct7 == F7_ALT && o_funct3 == F3_SR)
                        begin
                            o_alu_op = alu_sra;
                            o_valid  = 1'b1;
                        end
                end
            default:
                o_valid = 1'b0;
        endcase
    end

endmodule

// File: logic/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile
    import rv_core_pkg::*;
(
    input  logic                  i_clk,

    input  logic [REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [REG_ADDR_W-1:0] i_rs2_addr,
    output logic [XLEN-1:0]       o_rs1_data,
    output logic [XLEN-1:0]       o_rs2_data,

    input  logic                  i_wr_en,
    input  logic [REG_ADDR_W-1:0] i_wr_addr,
    input  logic [XLEN-1:0]       i_wr_data
);

// x0 has no storage
logic [XLEN-1:0] r_regs [1:NUM_GPR];

assign o_rs1_data = (i_rs1_addr == '0) ? '0 : r_regs[i_rs1_addr];
assign o_rs2_data = (i_rs2_addr == '0) ? '0 : r_regs[i_rs2_addr];

always_ff @(posedge i_clk)
    if (i_wr_en && i_wr_addr != '0)
        begin
            r_regs[i_wr_addr] <= i_wr_data;
        end

endmodule

// File: logic/rv_alu.sv
`timescale 1ns/10ps

module rv_alu
    import rv_core_pkg::*;
(
    input  alu_op_t         i_op,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    input  logic [2:0]      i_funct3,

    output logic [XLEN-1:0] o_result,
    output logic            o_branch_taken
);

logic [4:0] w_shamt;
logic       w_lt_signed;
logic       w_lt_unsigned;
logic       w_equal;

assign w_shamt       = i_b[4:0];
assign w_lt_signed   = ($signed(i_a) < $signed(i_b));
assign w_lt_unsigned = (i_a < i_b);
assign w_equal       = (i_a == i_b);

always_comb
    case (i_op)
        alu_add:    o_result = i_a + i_b;
        alu_sub:    o_result = i_a - i_b;
        alu_sll:    o_result = i_a << w_shamt;
        alu_slt:    o_result = { { (XLEN - 1) { 1'b0 } }, w_lt_signed };
        alu_sltu:   o_result = { { (XLEN - 1) { 1'b0 } }, w_lt_unsigned };
        alu_xor:    o_result = i_a ^ i_b;
        alu_srl:    o_result = i_a >> w_shamt;
        alu_sra:    o_result = $signed(i_a) >>> w_shamt;
        alu_or:     o_result = i_a | i_b;
        alu_and:    o_result = i_a & i_b;
        alu_pass_b: o_result = i_b;
        default:    o_result = '0;
    endcase

// the branch target is formed in control
always_comb
    case (i_funct3)
        F3_BEQ:  o_branch_taken = w_equal;
        F3_BNE:  o_branch_taken = !w_equal;
        F3_BLT:  o_branch_taken = w_lt_signed;
        F3_BGE:  o_branch_taken = !w_lt_signed;
        F3_BLTU: o_branch_taken = w_lt_unsigned;
        F3_BGEU: o_branch_taken = !w_lt_unsigned;
        default: o_branch_taken = 1'b0;
    endcase

endmodule

// File: logic/rv_control.sv
`timescale 1ns/10ps

module rv_control
    import rv_core_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_enable,

    input  logic [6:0]            i_opcode,
    input  logic [REG_ADDR_W-1:0] i_rd,
    input  logic [XLEN-1:0]       i_imm,
    input  alu_op_t               i_alu_op,
    input  instr_class_t          i_class,
    input  logic                  i_valid,
    output logic [XLEN-1:0]       o_instr,

    input  logic [XLEN-1:0]       i_rs1_data,
    input  logic [XLEN-1:0]       i_rs2_data,

    output alu_op_t               o_alu_op,
    output logic [XLEN-1:0]       o_alu_a,
    output logic [XLEN-1:0]       o_alu_b,
    input  logic [XLEN-1:0]       i_alu_result,
    input  logic                  i_branch_taken,

    output logic                  o_rf_wr_en,
    output logic [REG_ADDR_W-1:0] o_rf_wr_addr,
    output logic [XLEN-1:0]       o_rf_wr_data,

    output logic [XLEN-1:0]       o_mem_addr,
    output logic                  o_mem_read_en,
    output logic                  o_mem_write_en,
    output logic [XLEN-1:0]       o_mem_data,
    input  logic [XLEN-1:0]       i_mem_rdata,

    output logic                  o_halted
);

core_state_t r_state;

logic [XLEN-1:0] r_pc;
logic [XLEN-1:0] r_instr;

logic            w_step;
logic            w_uses_pc;
logic            w_uses_rs2;
logic            w_writes_rd;
logic            w_is_mem;
logic [XLEN-1:0] w_pc_seq;
logic [XLEN-1:0] w_next_pc;

assign o_instr = r_instr;

// a halted core behaves like a permanent pause
assign w_step = i_enable && !o_halted;

assign w_pc_seq = r_pc + INSTR_STEP;
assign w_is_mem = (i_class == class_load) || (i_class == class_store);

assign w_uses_pc  = (i_class == class_auipc) || (i_class == class_jal);
assign w_uses_rs2 = (i_class == class_branch) || (i_class == class_alu && i_opcode == OP_REG);

assign o_alu_a = w_uses_pc ? r_pc : i_rs1_data;
assign o_alu_b = w_uses_rs2 ? i_rs2_data : i_imm;

// address and jump targets all go through the adder
always_comb
    case (i_class)
        class_alu: o_alu_op = i_alu_op;
        class_lui: o_alu_op = alu_pass_b;
        default:   o_alu_op = alu_add;
    endcase

always_comb
    case (i_class)
        class_jal:    w_next_pc = i_alu_result;
        class_jalr:   w_next_pc = { i_alu_result[XLEN-1:1], 1'b0 };
        class_branch: w_next_pc = i_branch_taken ? (r_pc + i_imm) : w_pc_seq;
        default:      w_next_pc = w_pc_seq;
    endcase

assign w_writes_rd = i_valid && (i_class != class_branch) && !w_is_mem;

assign o_rf_wr_en = w_step && ((r_state == state_execute && w_writes_rd)
                               || r_state == state_load_done);
assign o_rf_wr_addr = i_rd;

always_comb
    if (r_state == state_load_done)
        o_rf_wr_data = i_mem_rdata;
    else if (i_class == class_jal || i_class == class_jalr)
        o_rf_wr_data = w_pc_seq;
    else
        o_rf_wr_data = i_alu_result;

always_ff @(posedge i_clk)
    if (i_rst)
        begin
            r_state        <= state_fetch;
            r_pc           <= '0;
            o_mem_read_en  <= 1'b0;
            o_mem_write_en <= 1'b0;
            o_halted       <= 1'b0;
        end
    else
        begin
            // strobes last one cycle
            o_mem_read_en  <= 1'b0;
            o_mem_write_en <= 1'b0;

            if (w_step)
                case (r_state)
                    state_fetch:
                        begin
                            o_mem_read_en <= 1'b1;
                            r_state       <= state_fetch_wait;
                        end
                    state_fetch_wait:
                        r_state <= state_decode;
                    state_decode:
                        r_state <= state_execute;
                    state_execute:
                        if (i_valid)
                            begin
                                r_pc           <= w_next_pc;
                                o_mem_read_en  <= (i_class == class_load);
                                o_mem_write_en <= (i_class == class_store);
                                r_state        <= (i_class == class_load) ? state_load_wait
                                                                          : state_fetch;
                            end
                        else
                            o_halted <= 1'b1;
                    state_load_wait:
                        r_state <= state_load_done;
                    default:
                        r_state <= state_fetch;
                endcase
        end

// bus address, store data and instruction word
always_ff @(posedge i_clk)
    if (w_step)
        begin
            if (r_state == state_fetch)
                o_mem_addr <= r_pc;
            else if (r_state == state_decode)
                r_instr <= i_mem_rdata;
            else if (r_state == state_execute && w_is_mem)
                begin
                    o_mem_addr <= i_alu_result;
                    o_mem_data <= i_rs2_data;
                end
        end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/10ps

module rv_core
    import rv_core_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_enable,

    output logic [XLEN-1:0] o_mem_addr,
    output logic [XLEN-1:0] o_mem_data,
    output logic            o_mem_read_en,
    output logic            o_mem_write_en,
    input  logic [XLEN-1:0] i_mem_rdata,

    output logic            o_halted
);

logic [XLEN-1:0]       w_instr;
logic [6:0]            w_opcode;
logic [REG_ADDR_W-1:0] w_rd;
logic [REG_ADDR_W-1:0] w_rs1;
logic [REG_ADDR_W-1:0] w_rs2;
logic [2:0]            w_funct3;
logic [XLEN-1:0]       w_imm;
alu_op_t               w_dec_alu_op;
instr_class_t          w_class;
logic                  w_valid;

logic [XLEN-1:0]       w_rs1_data;
logic [XLEN-1:0]       w_rs2_data;
logic                  w_rf_wr_en;
logic [REG_ADDR_W-1:0] w_rf_wr_addr;
logic [XLEN-1:0]       w_rf_wr_data;

alu_op_t               w_alu_op;
logic [XLEN-1:0]       w_alu_a;
logic [XLEN-1:0]       w_alu_b;
logic [XLEN-1:0]       w_alu_result;
logic                  w_branch_taken;

rv_decoder u_decoder
(
    .i_instr(w_instr),
    .o_opcode(w_opcode),
    .o_rd(w_rd),
    .o_rs1(w_rs1),
    .o_rs2(w_rs2),
    .o_funct3(w_funct3),
    .o_imm(w_imm),
    .o_alu_op(w_dec_alu_op),
    .o_class(w_class),
    .o_valid(w_valid)
);

rv_regfile u_regfile
(
    .i_clk(i_clk),
    .i_rs1_addr(w_rs1),
    .i_rs2_addr(w_rs2),
    .o_rs1_data(w_rs1_data),
    .o_rs2_data(w_rs2_data),
    .i_wr_en(w_rf_wr_en),
    .i_wr_addr(w_rf_wr_addr),
    .i_wr_data(w_rf_wr_data)
);

rv_alu u_alu
(
    .i_op(w_alu_op),
    .i_a(w_alu_a),
    .i_b(w_alu_b),
    .i_funct3(w_funct3),
    .o_result(w_alu_result),
    .o_branch_taken(w_branch_taken)
);

rv_control u_control
(
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_enable(i_enable),
    .i_opcode(w_opcode),
    .i_rd(w_rd),
    .i_imm(w_imm),
    .i_alu_op(w_dec_alu_op),
    .i_class(w_class),
    .i_valid(w_valid),
    .o_instr(w_instr),
    .i_rs1_data(w_rs1_data),
    .i_rs2_data(w_rs2_data),
    .o_alu_op(w_alu_op),
    .o_alu_a(w_alu_a),
    .o_alu_b(w_alu_b),
    .i_alu_result(w_alu_result),
    .i_branch_taken(w_branch_taken),
    .o_rf_wr_en(w_rf_wr_en),
    .o_rf_wr_addr(w_rf_wr_addr),
    .o_rf_wr_data(w_rf_wr_data),
    .o_mem_addr(o_mem_addr),
    .o_mem_read_en(o_mem_read_en),
    .o_mem_write_en(o_mem_write_en),
    .o_mem_data(o_mem_data),
    .i_mem_rdata(i_mem_rdata),
    .o_halted(o_halted)
);

endmodule

// File: test/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core
    import rv_core_pkg::*;
();

localparam logic [31:0] SEED = 32'h49a05846;

localparam int MEM_WORDS        = 1024;
localparam int DATA_ADDR        = 32'h0000_0700;
localparam int STORE_AREA       = 256;
localparam int BODY_END         = 31 + 300;
localparam int RESET_CYCLES     = 16;
localparam int TAIL_CYCLES      = 20;
localparam int MODEL_STEP_LIMIT = MEM_WORDS;

logic            i_clk;
logic            i_rst;
logic            i_enable;
logic [31:0]     i_mem_rdata;
logic [31:0]     o_mem_addr;
logic [31:0]     o_mem_data;
logic            o_mem_read_en;
logic            o_mem_write_en;
logic            o_halted;

logic [31:0] bus_mem  [0:MEM_WORDS-1];
logic [31:0] ref_mem  [0:MEM_WORDS-1];
logic [31:0] ref_regs [0:31];

// expected accesses as {is_write, address, data}
logic [64:0] exp_q [$];

logic [31:0] lfsr;
logic [31:0] rdata_next;
logic        rdata_pending;
logic        stretch_high;
logic        halt_seen;
int          gen_idx;
int          prog_words;
int          access_count;
int          cycle_count;
int          pause_cycles;
int          stretch_left;
int          tail_cycles;

rv_core i_dut
(
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_enable(i_enable),
    .o_mem_addr(o_mem_addr),
    .o_mem_data(o_mem_data),
    .o_mem_read_en(o_mem_read_en),
    .o_mem_write_en(o_mem_write_en),
    .i_mem_rdata(i_mem_rdata),
    .o_halted(o_halted)
);

initial
begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
end

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++)
    begin
        lfsr  = lfsr_step(lfsr);
        value = {value[30:0], lfsr[0]};
    end
    return value;
endfunction

task automatic fail_run(input string why);
    $display("FAILURE at %0t ns: %s", $time, why);
    $display("SOME TESTS FAILED");
    $fatal(1, "%s", why);
endtask

task automatic check_value(input string what, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected)
    begin
        $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, expected);
        $display("SOME TESTS FAILED");
        $fatal(1, "value mismatch");
    end
endtask

// instruction encoders
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// x2 holds the data base and is never written
function automatic logic [4:0] dest_reg(input logic [4:0] r);
    return (r == 5'd2) ? 5'd0 : r;
endfunction

task automatic emit_word(input logic [31:0] word);
    bus_mem[10'(gen_idx)] = word;
    gen_idx++;
endtask

task automatic emit_alu_op();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    r  = take_bits(32);
    f3 = r[2:0];
    if (r[3])
    begin
        f7 = (r[4] && (f3 == F3_ADD || f3 == F3_SR)) ? F7_ALT : F7_BASE;
        emit_word(enc_r(f7, r[9:5], r[14:10], f3, dest_reg(r[19:15])));
    end
    else if (f3 == F3_SLL || f3 == F3_SR)
    begin
        f7 = (r[4] && f3 == F3_SR) ? F7_ALT : F7_BASE;
        emit_word(enc_i({f7, r[9:5]}, r[14:10], f3, dest_reg(r[19:15]), OP_IMM));
    end
    else
        emit_word(enc_i(r[31:20], r[14:10], f3, dest_reg(r[19:15]), OP_IMM));
endtask

task automatic emit_fillers(input int count);
    for (int i = 0; i < count; i++)
        emit_alu_op();
endtask

task automatic emit_item();
    logic [31:0] r;
    logic [2:0]  bf3;
    logic [4:0]  base;
    logic [11:0] jimm;
    int          skip;
    r    = take_bits(32);
    skip = (r[31:30] == 2'd0) ? 1 : int'(r[31:30]);
    case (r[3:0])
        4'd9:
            emit_word(enc_u(r[29:10], dest_reg(r[8:4]), OP_LUI));
        4'd10:
            emit_word(enc_u(r[29:10], dest_reg(r[8:4]), OP_AUIPC));
        4'd11:
            emit_word(enc_i({4'd0, r[9:4], 2'b00}, 5'd2, F3_WORD, dest_reg(r[14:10]), OP_LOAD));
        4'd12:
            emit_word(enc_s({4'd0, r[9:4], 2'b00}, r[14:10], 5'd2, F3_WORD));
        4'd13:
        begin
            // 010 and 011 are not branches
            bf3 = (r[6:5] == 2'b01) ? {1'b1, r[5:4]} : r[6:4];
            emit_word(enc_b(13'(4 * (skip + 1)), r[11:7], r[16:12], bf3));
            emit_fillers(skip);
        end
        4'd14:
        begin
            emit_word(enc_j(21'(4 * (skip + 1)), dest_reg(r[8:4])));
            emit_fillers(skip);
        end
        4'd15:
        begin
            base = dest_reg(r[8:4]);
            if (base == 5'd0)
                base = 5'd1;
            // odd offsets check that bit 0 of the target is cleared
            jimm    = 12'(4 * skip + 4);
            jimm[0] = r[9];
            emit_word(enc_u(20'd0, base, OP_AUIPC));
            emit_word(enc_i(jimm, base, 3'b000, dest_reg(r[14:10]), OP_JALR));
            emit_fillers(skip - 1);
        end
        default:
            emit_alu_op();
    endcase
endtask

task automatic build_program();
    logic [31:0] r;
    for (int i = 0; i < MEM_WORDS; i++)
        bus_mem[10'(i)] = take_bits(32);
    gen_idx = 0;
    for (int n = 1; n < 32; n++)
    begin
        r = take_bits(12);
        if (n == 2)
            emit_word(enc_i(12'(DATA_ADDR), 5'd0, F3_ADD, 5'd2, OP_IMM));
        else
            emit_word(enc_i(r[11:0], 5'd0, F3_ADD, 5'(n), OP_IMM));
    end
    while (gen_idx < BODY_END)
        emit_item();
    // dump every register so all results reach the bus
    for (int n = 1; n < 32; n++)
        emit_word(enc_s(12'(STORE_AREA + 4 * n), 5'(n), 5'd2, F3_WORD));
    emit_word(32'd0);
    prog_words = gen_idx;
    for (int i = 0; i < MEM_WORDS; i++)
        ref_mem[10'(i)] = bus_mem[10'(i)];
endtask

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// instruction-set model that runs the whole program ahead of the DUT
task automatic run_model();
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] wr_val;
    logic        writes;
    logic        done;
    int          steps;
    for (int i = 0; i < 32; i++)
        ref_regs[5'(i)] = '0;
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    while (!done)
    begin
        exp_q.push_back({1'b0, pc, 32'd0});
        ins     = ref_mem[pc[11:2]];
        a       = ref_regs[ins[19:15]];
        b       = ref_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        next_pc = pc + 32'd4;
        writes  = 1'b1;
        wr_val  = '0;
        if (ins == 32'd0)
        begin
            done   = 1'b1;
            writes = 1'b0;
        end
        else
        begin
            case (ins[6:0])
                OP_LUI:
                    wr_val = {ins[31:12], 12'd0};
                OP_AUIPC:
                    wr_val = pc + {ins[31:12], 12'd0};
                OP_JAL:
                begin
                    wr_val  = pc + 32'd4;
                    next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                OP_JALR:
                begin
                    wr_val  = pc + 32'd4;
                    next_pc = (a + imm_i) & 32'hffff_fffe;
                end
                OP_BRANCH:
                begin
                    writes = 1'b0;
                    if (branch_ref(ins[14:12], a, b))
                        next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                OP_LOAD:
                begin
                    addr = a + imm_i;
                    exp_q.push_back({1'b0, addr, 32'd0});
                    wr_val = ref_mem[addr[11:2]];
                end
                OP_STORE:
                begin
                    writes = 1'b0;
                    addr   = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    exp_q.push_back({1'b1, addr, b});
                    ref_mem[addr[11:2]] = b;
                end
                OP_IMM:
                    wr_val = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
                OP_REG:
                    wr_val = alu_ref(ins[14:12], ins[30], a, b);
                default:
                    fail_run("reference model met an instruction it cannot run");
            endcase
        end
        if (writes && ins[11:7] != 5'd0)
            ref_regs[ins[11:7]] = wr_val;
        pc = next_pc;
        steps++;
        if (steps > MODEL_STEP_LIMIT)
            fail_run("reference model did not reach the end of the program");
    end
endtask

// random stretches of high and low enable
task automatic drive_enable();
    logic [31:0] r;
    if (stretch_left == 0)
    begin
        r            = take_bits(6);
        stretch_high = (r[5:4] != 2'b00);
        stretch_left = stretch_high ? 1 + int'(r[3:0]) : 1 + int'(r[2:0]);
    end
    stretch_left--;
    i_enable = stretch_high;
    if (!stretch_high)
        pause_cycles++;
endtask

// memory model and access checks at mid-cycle
task automatic watch_bus();
    logic [64:0] exp;
    if ($isunknown({o_mem_read_en, o_mem_write_en, o_halted}))
        fail_run("a bus strobe or the halt flag is unknown");
    if (o_mem_read_en || o_mem_write_en)
    begin
        if (o_mem_read_en && o_mem_write_en)
            fail_run("read and write strobes are high in the same cycle");
        if (exp_q.size() == 0)
            fail_run("bus access after the expected access sequence ended");
        exp = exp_q.pop_front();
        if (access_count == 0)
            check_value("first fetch address", o_mem_addr, 32'd0);
        check_value("access is a write", 32'(o_mem_write_en), 32'(exp[64]));
        check_value("access address", o_mem_addr, exp[63:32]);
        if (o_mem_write_en)
        begin
            check_value("store data", o_mem_data, exp[31:0]);
            bus_mem[o_mem_addr[11:2]] = o_mem_data;
        end
        else
        begin
            rdata_next    = bus_mem[o_mem_addr[11:2]];
            rdata_pending = 1'b1;
        end
        access_count++;
    end
endtask

initial
begin
    i_rst         = 1'b1;
    i_enable      = 1'b0;
    i_mem_rdata   = '0;
    lfsr          = SEED;
    rdata_next    = '0;
    rdata_pending = 1'b0;
    stretch_high  = 1'b1;
    halt_seen     = 1'b0;
    access_count  = 0;
    cycle_count   = 0;
    pause_cycles  = 0;
    stretch_left  = 0;
    tail_cycles   = 0;

    build_program();
    run_model();

    repeat (RESET_CYCLES) @(posedge i_clk);
    #1;
    i_rst    = 1'b0;
    i_enable = 1'b1;

    // idle bus before the first fetch
    @(negedge i_clk);
    check_value("read strobe after reset", 32'(o_mem_read_en), 32'd0);
    check_value("write strobe after reset", 32'(o_mem_write_en), 32'd0);
    check_value("halt flag after reset", 32'(o_halted), 32'd0);

    while (!halt_seen || tail_cycles < TAIL_CYCLES)
    begin
        @(posedge i_clk);
        #1;
        if (rdata_pending)
        begin
            i_mem_rdata   = rdata_next;
            rdata_pending = 1'b0;
        end
        drive_enable();
        cycle_count++;
        if (cycle_count > prog_words * 6 + pause_cycles + 200)
            fail_run("timeout, the core did not halt in time");

        @(negedge i_clk);
        watch_bus();
        if (halt_seen)
        begin
            check_value("halt flag stays high", 32'(o_halted), 32'd1);
            tail_cycles++;
        end
        else if (o_halted)
        begin
            halt_seen = 1'b1;
            if (exp_q.size() != 0)
                fail_run("core halted before all expected bus accesses");
        end
    end

    $display("ALL TESTS PASSED");
    $finish;
end

endmodule

// File: flist.f
logic/rv_core_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_control.sv
logic/rv_core.sv
test/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_rv_core \
    -f flist.f \
    --Mdir build \
    -o tb_rv_core

./build/tb_rv_core
